// File: Makefile
# Verilator build and run of the memory-mapped RAM testbench

VERILATOR ?= verilator
TOP       ?= tb_mm_ram
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(BUILD_DIR)

// File: logic/addr_decoder.sv
// address decoder for fetch and data ports with ROM arbitration and grants
`default_nettype none

`include "mm_ram_consts.svh"

module addr_decoder (
    input  logic                          instr_req_i,
    input  logic [31:0]                   instr_addr_i,
    input  mm_ram_pkg::data_req_t         data_i,
    output logic                          instr_gnt_o,
    output logic                          data_gnt_o,
    output mm_ram_pkg::ram_req_t          ram_data_o,
    output logic                          ram_instr_en_o,
    output logic [`MM_RAM_ADDR_WIDTH-3:0] ram_instr_addr_o,
    output mm_ram_pkg::periph_wr_t        periph_o,
    output mm_ram_pkg::rsel_e             data_rsel_o,
    output mm_ram_pkg::rsel_e             instr_rsel_o,
    output logic                          data_ack_o,
    output logic                          instr_ack_o
);

    import mm_ram_pkg::*;

    localparam int unsigned OFS_W = $clog2(`MM_PERIPH_LEN) - 2;

    region_e data_region;
    region_e instr_region;

    // subtract first so windows near the top of the space cannot wrap
    function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
                                       input logic [31:0] len);
        return (addr >= base) && ((addr - base) < len);
    endfunction

    function automatic region_e classify(input logic [31:0] addr);
        region_e region;
        if (in_window(addr, `MM_SRAM_BASE, `MM_SRAM_LEN) || addr < `MM_SRAM_LEN) begin
            region = REGION_RAM;
        end else if (in_window(addr, `MM_ROM_BASE, `MM_ROM_LEN)) begin
            region = REGION_ROM;
        end else if (in_window(addr, `MM_CNTRL_BASE, `MM_PERIPH_LEN)) begin
            region = REGION_CNTRL;
        end else if (in_window(addr, `MM_STDOUT_BASE, `MM_PERIPH_LEN)) begin
            region = REGION_STDOUT;
        end else if (in_window(addr, `MM_TIMER_BASE, `MM_PERIPH_LEN)) begin
            region = REGION_TIMER;
        end else begin
            region = REGION_UNMAP;
        end
        return region;
    endfunction

    // peripherals and holes read back as zero
    function automatic rsel_e read_sel(input region_e region);
        rsel_e sel;
        case (region)
            REGION_RAM: sel = RSEL_RAM;
            REGION_ROM: sel = RSEL_LOOP;
            default:    sel = RSEL_ZERO;
        endcase
        return sel;
    endfunction

    assign data_region  = classify(data_i.addr);
    assign instr_region = classify(instr_addr_i);

    // the core data port is never stalled
    assign data_gnt_o = data_i.req;
    assign data_ack_o = data_i.req;

    // RAM fetches have their own port, everything else waits for a free data path
    assign instr_gnt_o = instr_req_i && (instr_region == REGION_RAM || !data_i.req);
    assign instr_ack_o = instr_gnt_o;

    assign ram_instr_en_o   = instr_req_i && (instr_region == REGION_RAM);
    assign ram_instr_addr_o = instr_addr_i[`MM_RAM_ADDR_WIDTH-1:2];

    always_comb begin
        // upper address bits are clipped, which folds the mirror onto the base
        ram_data_o.en    = data_i.req && (data_region == REGION_RAM);
        ram_data_o.we    = data_i.req && data_i.we && (data_region == REGION_RAM);
        ram_data_o.be    = data_i.be;
        ram_data_o.addr  = data_i.addr[`MM_RAM_ADDR_WIDTH-1:2];
        ram_data_o.wdata = data_i.wdata;
    end

    always_comb begin
        periph_o.wr     = data_i.req && data_i.we;
        periph_o.region = data_region;
        periph_o.ofs    = data_i.addr[OFS_W+1:2];
    end

    always_comb begin
        if (!data_i.req) begin
            data_rsel_o = RSEL_IDLE;
        end else if (data_i.we) begin
            // write responses carry no data
            data_rsel_o = RSEL_ZERO;
        end else begin
            data_rsel_o = read_sel(data_region);
        end
        instr_rsel_o = instr_gnt_o ? read_sel(instr_region) : RSEL_IDLE;
    end

    // ROM and unmapped fetches share the response path with the data port
    rom_fetch_arbitrated: assert final (!(instr_ack_o && data_ack_o &&
                                          instr_rsel_o != RSEL_RAM))
        else $error("fetch outside RAM acknowledged alongside a data request");

endmodule

`default_nettype wire

// File: logic/dual_port_ram.sv
// dual-port RAM with a read-only fetch port and a byte-enabled data port
`default_nettype none

module dual_port_ram #(
    parameter int unsigned ADDR_WIDTH = 16
) (
    input  logic                  clk_i,

    // fetch port, read only
    input  logic                  instr_en_i,
    input  logic [ADDR_WIDTH-3:0] instr_addr_i,
    output logic [31:0]           instr_rdata_o,

    // core data port
    input  mm_ram_pkg::ram_req_t  data_i,
    output logic [31:0]           data_rdata_o
);

    localparam int unsigned WORDS = 2 ** (ADDR_WIDTH - 2);

    logic [31:0] mem [WORDS];

    // byte lanes written on the granting edge
    always_ff @(posedge clk_i) begin
        if (data_i.en && data_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (data_i.be[b]) begin
                    mem[data_i.addr][8*b +: 8] <= data_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data shows up on the edge after the request, old data on collision
    always_ff @(posedge clk_i) begin
        if (data_i.en) begin
            data_rdata_o <= mem[data_i.addr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            instr_rdata_o <= mem[instr_addr_i];
        end
    end

    // decoder must qualify every write with the enable
    we_needs_en: assert property (@(posedge clk_i) data_i.we |-> data_i.en)
        else $error("RAM write enable without enable");

endmodule

`default_nettype wire

// File: logic/mm_ram_consts.svh
// memory map windows, RAM size, loop word, pass code and timer interrupt id
`ifndef MM_RAM_CONSTS_SVH
`define MM_RAM_CONSTS_SVH

// RAM window, also mirrored at address zero
`define MM_SRAM_BASE 32'h1C00_0000

// byte-address width of the RAM (64 KiB)
`define MM_RAM_ADDR_WIDTH 16
`define MM_SRAM_LEN (32'd1 << `MM_RAM_ADDR_WIDTH)

// boot ROM region, every read returns the loop word
`define MM_ROM_BASE 32'h1A00_0000
`define MM_ROM_LEN 32'h0000_1000

// pseudo-peripheral windows
`define MM_CNTRL_BASE 32'h1A10_4000
`define MM_STDOUT_BASE 32'h1A10_F000
`define MM_TIMER_BASE 32'h1A10_B000
`define MM_PERIPH_LEN 32'h0000_1000

// byte offsets inside the timer window
`define MM_TIMER_MASK_OFS 32'h0000_0000
`define MM_TIMER_CNT_OFS 32'h0000_0004

// jal x0, 0 keeps a JTAG-booted core spinning
`define MM_LOOP_WORD 32'h0000_006F

// CNTRL write value that signals a passing test
`define MM_PASS_CODE 32'h0000_F00D

`define MM_TIMER_IRQ_ID 5'd3

`endif

// File: logic/mm_ram_pkg.sv
// region and read-select enums plus the data, RAM and peripheral request structs
`default_nettype none

`include "mm_ram_consts.svh"

package mm_ram_pkg;

    // decoded target of one access
    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_ROM,
        REGION_CNTRL,
        REGION_STDOUT,
        REGION_TIMER,
        REGION_UNMAP
    } region_e;

    // source of the read data returned one cycle after the grant
    typedef enum logic [1:0] {
        RSEL_RAM,
        RSEL_LOOP,
        RSEL_ZERO,
        RSEL_IDLE
    } rsel_e;

    // core data port request
    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

    // RAM data port request, addressed by word
    typedef struct packed {
        logic                            en;
        logic                            we;
        logic [3:0]                      be;
        logic [`MM_RAM_ADDR_WIDTH-3:0]   addr;
        logic [31:0]                     wdata;
    } ram_req_t;

    // peripheral write, word offset inside a 4 KiB window
    typedef struct packed {
        logic                                 wr;
        region_e                              region;
        logic [$clog2(`MM_PERIPH_LEN)-3:0]    ofs;
    } periph_wr_t;

endpackage

`default_nettype wire

// File: logic/mm_ram_top.sv
// memory-mapped RAM wrapper top with decoder, RAM, peripherals and responses
`default_nettype none

`include "mm_ram_consts.svh"

module mm_ram_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  instr_req_i,
    input  logic [31:0]           instr_addr_i,
    output logic                  instr_gnt_o,
    output logic                  instr_rvalid_o,
    output logic [31:0]           instr_rdata_o,

    input  mm_ram_pkg::data_req_t data_i,
    output logic                  data_gnt_o,
    output logic                  data_rvalid_o,
    output logic [31:0]           data_rdata_o,

    input  logic                  irq_ack_i,
    input  logic [4:0]            irq_id_i,
    output logic                  irq_o,
    output logic [4:0]            irq_id_o,

    output logic                  tests_passed_o,
    output logic                  tests_failed_o,
    output logic                  print_valid_o,
    output logic [31:0]           print_data_o
);

    import mm_ram_pkg::*;

    ram_req_t                      ram_data_req;
    logic                          ram_instr_en;
    logic [`MM_RAM_ADDR_WIDTH-3:0] ram_instr_addr;
    logic [31:0]                   ram_data_rdata;
    logic [31:0]                   ram_instr_rdata;

    periph_wr_t                    periph_wr;
    rsel_e                         data_rsel;
    rsel_e                         instr_rsel;
    logic                          data_ack;
    logic                          instr_ack;

    logic                          timer_load;
    logic [31:0]                   timer_value;
    logic                          timer_irq_en;

    addr_decoder addr_decoder_i (
        .instr_req_i      (instr_req_i),
        .instr_addr_i     (instr_addr_i),
        .data_i           (data_i),
        .instr_gnt_o      (instr_gnt_o),
        .data_gnt_o       (data_gnt_o),
        .ram_data_o       (ram_data_req),
        .ram_instr_en_o   (ram_instr_en),
        .ram_instr_addr_o (ram_instr_addr),
        .periph_o         (periph_wr),
        .data_rsel_o      (data_rsel),
        .instr_rsel_o     (instr_rsel),
        .data_ack_o       (data_ack),
        .instr_ack_o      (instr_ack)
    );

    dual_port_ram #(
        .ADDR_WIDTH (`MM_RAM_ADDR_WIDTH)
    ) dual_port_ram_i (
        .clk_i         (clk_i),
        .instr_en_i    (ram_instr_en),
        .instr_addr_i  (ram_instr_addr),
        .instr_rdata_o (ram_instr_rdata),
        .data_i        (ram_data_req),
        .data_rdata_o  (ram_data_rdata)
    );

    // peripheral writes reuse the data port write data
    periph_regs periph_regs_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .periph_i       (periph_wr),
        .wdata_i        (data_i.wdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .print_valid_o  (print_valid_o),
        .print_data_o   (print_data_o),
        .timer_load_o   (timer_load),
        .timer_value_o  (timer_value),
        .timer_irq_en_o (timer_irq_en)
    );

    sys_timer sys_timer_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .load_i    (timer_load),
        .value_i   (timer_value),
        .irq_en_i  (timer_irq_en),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o)
    );

    resp_mux resp_mux_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .data_rsel_i       (data_rsel),
        .instr_rsel_i      (instr_rsel),
        .data_ack_i        (data_ack),
        .instr_ack_i       (instr_ack),
        .ram_data_rdata_i  (ram_data_rdata),
        .ram_instr_rdata_i (ram_instr_rdata),
        .data_rvalid_o     (data_rvalid_o),
        .data_rdata_o      (data_rdata_o),
        .instr_rvalid_o    (instr_rvalid_o),
        .instr_rdata_o     (instr_rdata_o)
    );

    // only the timer raises interrupts here
    assign irq_id_o = `MM_TIMER_IRQ_ID;

endmodule

`default_nettype wire

// File: logic/periph_regs.sv
// test-control, stdout and timer mask registers
`default_nettype none

`include "mm_ram_consts.svh"

module periph_regs (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  mm_ram_pkg::periph_wr_t periph_i,
    input  logic [31:0]            wdata_i,

    output logic                   tests_passed_o,
    output logic                   tests_failed_o,
    output logic                   print_valid_o,
    output logic [31:0]            print_data_o,

    output logic                   timer_load_o,
    output logic [31:0]            timer_value_o,
    output logic                   timer_irq_en_o
);

    import mm_ram_pkg::*;

    logic cntrl_wr;
    logic timer_wr;
    logic mask_wr;
    logic irq_en_q;

    assign cntrl_wr = periph_i.wr && (periph_i.region == REGION_CNTRL);
    assign timer_wr = periph_i.wr && (periph_i.region == REGION_TIMER);

    // pass or fail pulse in the grant cycle
    assign tests_passed_o = cntrl_wr && (wdata_i == `MM_PASS_CODE);
    assign tests_failed_o = cntrl_wr && (wdata_i != `MM_PASS_CODE);

    assign print_valid_o = periph_i.wr && (periph_i.region == REGION_STDOUT);
    assign print_data_o  = print_valid_o ? wdata_i : '0;

    // timer registers, selected by word offset
    assign mask_wr       = timer_wr && (periph_i.ofs == ($bits(periph_i.ofs))'(`MM_TIMER_MASK_OFS >> 2));
    assign timer_load_o  = timer_wr && (periph_i.ofs == ($bits(periph_i.ofs))'(`MM_TIMER_CNT_OFS >> 2));
    assign timer_value_o = wdata_i;

    // only the timer id bit of the mask has any effect
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_en_q <= 1'b0;
        end else if (mask_wr) begin
            irq_en_q <= wdata_i[`MM_TIMER_IRQ_ID];
        end
    end

    assign timer_irq_en_o = irq_en_q;

endmodule

`default_nettype wire

// File: logic/resp_mux.sv
// registered read selects, rvalid pulses and read data muxing per port
`default_nettype none

`include "mm_ram_consts.svh"

module resp_mux (
    input  logic              clk_i,
    input  logic              rst_ni,

    input  mm_ram_pkg::rsel_e data_rsel_i,
    input  mm_ram_pkg::rsel_e instr_rsel_i,
    input  logic              data_ack_i,
    input  logic              instr_ack_i,

    input  logic [31:0]       ram_data_rdata_i,
    input  logic [31:0]       ram_instr_rdata_i,

    output logic              data_rvalid_o,
    output logic [31:0]       data_rdata_o,
    output logic              instr_rvalid_o,
    output logic [31:0]       instr_rdata_o
);

    import mm_ram_pkg::*;

    rsel_e data_rsel_q;
    rsel_e instr_rsel_q;

    function automatic logic [31:0] pick(input rsel_e sel, input logic [31:0] ram_rdata);
        logic [31:0] rdata;
        case (sel)
            RSEL_RAM:  rdata = ram_rdata;
            RSEL_LOOP: rdata = `MM_LOOP_WORD;
            default:   rdata = '0;
        endcase
        return rdata;
    endfunction

    // one rvalid per granted access, one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rsel_q    <= RSEL_IDLE;
            instr_rsel_q   <= RSEL_IDLE;
            data_rvalid_o  <= 1'b0;
            instr_rvalid_o <= 1'b0;
        end else begin
            data_rsel_q    <= data_rsel_i;
            instr_rsel_q   <= instr_rsel_i;
            data_rvalid_o  <= data_ack_i;
            instr_rvalid_o <= instr_ack_i;
        end
    end

    assign data_rdata_o  = pick(data_rsel_q, ram_data_rdata_i);
    assign instr_rdata_o = pick(instr_rsel_q, ram_instr_rdata_i);

endmodule

`default_nettype wire

// File: logic/sys_timer.sv
// countdown timer with interrupt request and acknowledge
`default_nettype none

`include "mm_ram_consts.svh"

module sys_timer (
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic        load_i,
    input  logic [31:0] value_i,
    input  logic        irq_en_i,

    input  logic        irq_ack_i,
    input  logic [4:0]  irq_id_i,
    output logic        irq_o
);

    logic [31:0] cnt_q;
    logic        irq_q;
    logic        expire;
    logic        ack;

    // 1 -> 0 transition, a fresh load takes precedence
    assign expire = !load_i && (cnt_q == 32'd1);
    assign ack    = irq_ack_i && (irq_id_i == `MM_TIMER_IRQ_ID);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= value_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 32'd1;
        end
    end

    // acknowledge wins over a new expiry in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q <= 1'b0;
        end else if (ack) begin
            irq_q <= 1'b0;
        end else if (expire && irq_en_i) begin
            irq_q <= 1'b1;
        end
    end

    assign irq_o = irq_q;

    load_beats_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                       load_i |=> cnt_q == $past(value_i))
        else $error("timer counted down during a load");

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/mm_ram_pkg.sv
logic/addr_decoder.sv
logic/dual_port_ram.sv
logic/periph_regs.sv
logic/sys_timer.sv
logic/resp_mux.sv
logic/mm_ram_top.sv
sim/tb_mm_ram.sv

// File: sim/tb_mm_ram.sv
// memory-mapped RAM wrapper testbench with access table, reference model and timer checks
`default_nettype none

`include "mm_ram_consts.svh"

module tb_mm_ram;

    import mm_ram_pkg::*;

    localparam int unsigned N_WORDS = 8;
    localparam int unsigned TIMER_N = 5;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_FETCH,
        OP_FETCH_DATA,
        OP_FETCH_BLOCKED
    } op_e;

    // for writes exp holds the expected pulses {print, failed, passed}
    // addr2 and exp2 belong to the data read that runs beside a fetch
    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] addr2;
        logic [31:0] exp2;
    } entry_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        instr_req_i;
    logic [31:0] instr_addr_i;
    logic        instr_gnt_o;
    logic        instr_rvalid_o;
    logic [31:0] instr_rdata_o;
    data_req_t   data_i;
    logic        data_gnt_o;
    logic        data_rvalid_o;
    logic [31:0] data_rdata_o;
    logic        irq_ack_i;
    logic [4:0]  irq_id_i;
    logic        irq_o;
    logic [4:0]  irq_id_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        print_valid_o;
    logic [31:0] print_data_o;

    entry_t      table_q[$];
    logic [31:0] model [N_WORDS];
    logic [31:0] word_idx [N_WORDS];
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    mm_ram_top mm_ram_top_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_i         (data_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .irq_id_o       (irq_id_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .print_valid_o  (print_valid_o),
        .print_data_o   (print_data_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // same RAM word seen through the SRAM base or through the mirror at zero
    function automatic logic [31:0] ram_addr(input int k, input logic mirror);
        return (mirror ? 32'h0 : `MM_SRAM_BASE) + (word_idx[k] << 2);
    endfunction

    function automatic void add_entry(input op_e op, input logic [31:0] addr,
                                      input logic [3:0] be, input logic [31:0] data,
                                      input logic [31:0] exp, input logic [31:0] addr2,
                                      input logic [31:0] exp2);
        entry_t e;
        e.op    = op;
        e.addr  = addr;
        e.be    = be;
        e.data  = data;
        e.exp   = exp;
        e.addr2 = addr2;
        e.exp2  = exp2;
        table_q.push_back(e);
    endfunction

    task automatic build_table();
        logic [3:0]  be;
        logic [31:0] wdata;
        // low index bits hold k, so the words never collide
        for (int k = 0; k < N_WORDS; k++) begin
            word_idx[k] = 32'({11'($urandom_range(2047, 0)), 3'(k)});
            model[k]    = $urandom;
            add_entry(OP_WRITE, ram_addr(k, k % 2 == 0), 4'hF, model[k], '0, '0, '0);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            be       = 4'($urandom_range(15, 0));
            wdata    = $urandom;
            model[k] = merge_bytes(model[k], wdata, be);
            add_entry(OP_WRITE, ram_addr(k, k % 2 == 1), be, wdata, '0, '0, '0);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            add_entry(OP_READ, ram_addr(k, 1'b0), 4'hF, '0, model[k], '0, '0);
            add_entry(OP_READ, ram_addr(k, 1'b1), 4'hF, '0, model[k], '0, '0);
            add_entry(OP_FETCH, ram_addr(k, k >= 4), 4'h0, '0, model[k], '0, '0);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry(OP_FETCH_DATA, ram_addr(k, 1'b0), 4'hF, '0, model[k],
                      ram_addr(k + 4, 1'b1), model[k + 4]);
        end
        add_entry(OP_FETCH, `MM_ROM_BASE + 32'h10, 4'h0, '0, `MM_LOOP_WORD, '0, '0);
        add_entry(OP_READ, `MM_ROM_BASE + 32'hFFC, 4'hF, '0, `MM_LOOP_WORD, '0, '0);
        add_entry(OP_READ, 32'h3000_0000, 4'hF, '0, '0, '0, '0);
        add_entry(OP_FETCH, 32'h3000_0000, 4'h0, '0, '0, '0, '0);
        add_entry(OP_READ, `MM_CNTRL_BASE, 4'hF, '0, '0, '0, '0);
        add_entry(OP_READ, `MM_STDOUT_BASE + 32'h8, 4'hF, '0, '0, '0, '0);
        add_entry(OP_FETCH_BLOCKED, `MM_ROM_BASE, 4'hF, '0, `MM_LOOP_WORD,
                  ram_addr(0, 1'b0), model[0]);
        add_entry(OP_WRITE, `MM_CNTRL_BASE, 4'hF, `MM_PASS_CODE, 32'b001, '0, '0);
        add_entry(OP_WRITE, `MM_CNTRL_BASE, 4'hF, 32'h0000_BAD0, 32'b010, '0, '0);
        add_entry(OP_WRITE, `MM_STDOUT_BASE, 4'hF, 32'h4865_6C6C, 32'b100, '0, '0);
    endtask

    task automatic drive_data(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata);
        data_req_t req;
        req.req   = 1'b1;
        req.we    = we;
        req.be    = be;
        req.addr  = addr;
        req.wdata = wdata;
        data_i <= req;
    endtask

    task automatic run_write(input entry_t e);
        @(posedge clk_i);
        drive_data(1'b1, e.be, e.addr, e.data);
        @(negedge clk_i);
        check_value("data_gnt", 32'(data_gnt_o), 32'd1);
        check_value("tests_passed", 32'(tests_passed_o), 32'(e.exp[0]));
        check_value("tests_failed", 32'(tests_failed_o), 32'(e.exp[1]));
        check_value("print_valid", 32'(print_valid_o), 32'(e.exp[2]));
        if (e.exp[2]) begin
            check_value("print_data", print_data_o, e.data);
        end
        @(posedge clk_i);
        data_i <= '0;
        @(negedge clk_i);
        check_value("data_rvalid", 32'(data_rvalid_o), 32'd1);
        check_value("write rdata", data_rdata_o, 32'h0);
    endtask

    task automatic run_read(input entry_t e);
        @(posedge clk_i);
        drive_data(1'b0, e.be, e.addr, '0);
        @(negedge clk_i);
        check_value("data_gnt", 32'(data_gnt_o), 32'd1);
        @(posedge clk_i);
        data_i <= '0;
        @(negedge clk_i);
        check_value("data_rvalid", 32'(data_rvalid_o), 32'd1);
        check_value("data_rdata", data_rdata_o, e.exp);
    endtask

    // a fetch alone, or together with a data read when with_data is set
    task automatic run_fetch(input entry_t e, input logic with_data);
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= e.addr;
        if (with_data) begin
            drive_data(1'b0, e.be, e.addr2, '0);
        end
        @(negedge clk_i);
        check_value("instr_gnt", 32'(instr_gnt_o), 32'd1);
        check_value("data_gnt", 32'(data_gnt_o), 32'(with_data));
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        data_i      <= '0;
        @(negedge clk_i);
        check_value("instr_rvalid", 32'(instr_rvalid_o), 32'd1);
        check_value("instr_rdata", instr_rdata_o, e.exp);
        if (with_data) begin
            check_value("data_rvalid", 32'(data_rvalid_o), 32'd1);
            check_value("data_rdata", data_rdata_o, e.exp2);
        end
    endtask

    // ROM fetch held off by a data read, granted once the data port is free
    task automatic run_fetch_blocked(input entry_t e);
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= e.addr;
        drive_data(1'b0, e.be, e.addr2, '0);
        @(negedge clk_i);
        check_value("data_gnt", 32'(data_gnt_o), 32'd1);
        check_value("instr_gnt beside data", 32'(instr_gnt_o), 32'd0);
        @(posedge clk_i);
        data_i <= '0;
        @(negedge clk_i);
        check_value("instr_gnt on retry", 32'(instr_gnt_o), 32'd1);
        check_value("instr_rvalid ungranted", 32'(instr_rvalid_o), 32'd0);
        check_value("data_rvalid", 32'(data_rvalid_o), 32'd1);
        check_value("data_rdata", data_rdata_o, e.exp2);
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        @(negedge clk_i);
        check_value("instr_rvalid", 32'(instr_rvalid_o), 32'd1);
        check_value("instr_rdata", instr_rdata_o, e.exp);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    task automatic run_entry(input entry_t e);
        int errors_before;
        errors_before = errors;
        case (e.op)
            OP_WRITE:         run_write(e);
            OP_READ:          run_read(e);
            OP_FETCH:         run_fetch(e, 1'b0);
            OP_FETCH_DATA:    run_fetch(e, 1'b1);
            OP_FETCH_BLOCKED: run_fetch_blocked(e);
            default: begin
                $display("table entry has an unknown operation");
                errors++;
            end
        endcase
        report_test($sformatf("%s %h", e.op.name(), e.addr), errors_before);
    endtask

    task automatic timer_write(input logic [31:0] ofs, input logic [31:0] value);
        entry_t e;
        e      = '0;
        e.op   = OP_WRITE;
        e.addr = `MM_TIMER_BASE + ofs;
        e.be   = 4'hF;
        e.data = value;
        run_write(e);
    endtask

    task automatic send_ack(input logic [4:0] id);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        irq_id_i  <= '0;
        @(negedge clk_i);
    endtask

    task automatic run_timer_irq();
        int errors_before;
        int cycles;
        errors_before = errors;
        timer_write(32'(`MM_TIMER_MASK_OFS), 32'd1 << `MM_TIMER_IRQ_ID);
        timer_write(32'(`MM_TIMER_CNT_OFS), TIMER_N);
        // loaded with N on the last edge, so it reaches zero N edges later
        check_value("irq after load", 32'(irq_o), 32'd0);
        cycles = 0;
        while (!irq_o && cycles < TIMER_N + 8) begin
            @(negedge clk_i);
            cycles++;
        end
        check_value("cycles until irq", cycles, TIMER_N);
        check_value("irq_id", 32'(irq_id_o), 32'(`MM_TIMER_IRQ_ID));
        send_ack(5'd5);
        check_value("irq after foreign ack", 32'(irq_o), 32'd1);
        send_ack(`MM_TIMER_IRQ_ID);
        check_value("irq after timer ack", 32'(irq_o), 32'd0);
        report_test("timer irq with mask set", errors_before);
    endtask

    task automatic run_timer_masked();
        int errors_before;
        errors_before = errors;
        timer_write(32'(`MM_TIMER_MASK_OFS), 32'd0);
        timer_write(32'(`MM_TIMER_CNT_OFS), TIMER_N);
        repeat (TIMER_N + 4) begin
            @(negedge clk_i);
            check_value("masked irq", 32'(irq_o), 32'd0);
        end
        report_test("timer irq with mask clear", errors_before);
    endtask

    task automatic run_reset_check();
        int errors_before;
        errors_before = errors;
        @(negedge clk_i);
        check_value("data_rvalid", 32'(data_rvalid_o), 32'd0);
        check_value("instr_rvalid", 32'(instr_rvalid_o), 32'd0);
        check_value("irq", 32'(irq_o), 32'd0);
        check_value("tests_passed", 32'(tests_passed_o), 32'd0);
        check_value("tests_failed", 32'(tests_failed_o), 32'd0);
        check_value("print_valid", 32'(print_valid_o), 32'd0);
        report_test("reset state", errors_before);
    endtask

    initial begin
        void'($urandom(30590));
        rst_ni       <= 1'b0;
        // requests stay up through reset and must not produce an rvalid
        instr_req_i  <= 1'b1;
        instr_addr_i <= '0;
        drive_data(1'b0, 4'hF, 32'h0, '0);
        irq_ack_i    <= 1'b0;
        irq_id_i     <= '0;
        build_table();
        cycle_limit = table_q.size() * 40 + 200;
        repeat (4) @(posedge clk_i);
        rst_ni      <= 1'b1;
        instr_req_i <= 1'b0;
        data_i      <= '0;
        run_reset_check();
        foreach (table_q[n]) begin
            run_entry(table_q[n]);
        end
        run_timer_irq();
        run_timer_masked();
        $display("tests run: %0d, tests failed: %0d, mismatches: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
